//--- Makefile
# Verilator build for the store benchmark and its testbench

OBJ = obj_dir

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tbBench -o simv
	./$(OBJ)/simv

lint:
	verilator --lint-only --assert -Wall -f list.f --top-module benchTop

clean:
	rm -rf $(OBJ)

.PHONY: all run lint clean

//--- benchApbRegs.sv
`timescale 1ns/1ps

module benchApbRegs #(
  parameter int ProgramDepth = 64
) (
  input  logic clk,
  input  logic reset,
  input  logic [7:0] paddr,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  benchPkg::apbData pwdata,
  output benchPkg::apbData prdata,
  output logic pready,
  output logic pslverr,
  input  logic running,
  input  logic done,
  input  logic failed,
  input  logic [$clog2(ProgramDepth)-1:0] failAddress,
  output logic start,
  output logic vecWrite,
  output logic [$clog2(ProgramDepth)-1:0] vecWriteAddress,
  output benchPkg::vectorWord vecWriteData
);

  localparam int AddrWidth = $clog2(ProgramDepth);

  logic setupPhase;
  logic accessPhase;
  logic mapped;
  logic runLocked;
  logic writeOk;
  benchPkg::apbData stageLow;
  benchPkg::apbData stageHigh;

  assign setupPhase = psel && !penable;
  assign accessPhase = psel && penable;

  always_comb begin
    case (paddr)
      benchPkg::regControl, benchPkg::regStatus, benchPkg::regVectorLow,
      benchPkg::regVectorHigh, benchPkg::regVectorCommit,
      benchPkg::regFailAddress: mapped = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  // Program and control writes are refused while a run is active
  assign runLocked = running && pwrite && (paddr inside {benchPkg::regControl,
      benchPkg::regVectorLow, benchPkg::regVectorHigh, benchPkg::regVectorCommit});

  // No wait states
  assign pready = 1'b1;
  assign pslverr = accessPhase && (!mapped || runLocked);
  assign writeOk = accessPhase && pwrite && mapped && !runLocked;

  always_ff @(posedge clk) begin
    if (!reset) begin
      start <= 1'b0;
    end else begin
      start <= writeOk && (paddr == benchPkg::regControl) && pwdata[0];
    end
  end

  //////////////////////////////////////////////////
  // Vector staging
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (writeOk && (paddr == benchPkg::regVectorLow)) begin
      stageLow <= pwdata;
    end
    if (writeOk && (paddr == benchPkg::regVectorHigh)) begin
      stageHigh <= pwdata;
    end
  end

  // Commit writes the staged word at the address carried in pwdata
  assign vecWrite = writeOk && (paddr == benchPkg::regVectorCommit);
  assign vecWriteAddress = pwdata[AddrWidth-1:0];
  assign vecWriteData = {stageHigh, stageLow};

  always_comb begin
    prdata = '0;
    if (accessPhase && !pwrite) begin
      case (paddr)
        benchPkg::regStatus: prdata = {29'd0, done && !failed, done, running};
        benchPkg::regVectorLow: prdata = stageLow;
        benchPkg::regVectorHigh: prdata = stageHigh;
        benchPkg::regFailAddress: prdata = benchPkg::apbData'(failAddress);
        default: prdata = '0;
      endcase
    end
  end

  paddrStable: assert property (@(posedge clk) disable iff (!reset)
    setupPhase |=> $stable(paddr));

  startWhileIdle: assert property (@(posedge clk) disable iff (!reset)
    start |-> !running);

endmodule

//--- benchPkg.sv
package benchPkg;

  typedef logic [63:0] vectorWord;
  typedef logic [7:0] byteValue;
  typedef logic [7:0] handleId;
  typedef logic [7:0] indexId;
  typedef logic [7:0] selectorCode;
  typedef logic [31:0] apbData;

  typedef enum logic [2:0] {
    opNone,
    opWrite,
    opClear,
    opRead,
    opCount
  } storeOp;

  // Vector word layout
  localparam int mutatingBit = 0;
  localparam int expectBoolBit = 1;
  localparam int endBit = 2;
  localparam int handleLsb = 8;
  localparam int indexLsb = 16;
  localparam int valueLsb = 24;
  localparam int selectorLsb = 32;
  localparam int expectValueLsb = 40;

  localparam selectorCode selWrite = 8'd1;
  localparam selectorCode selClear = 8'd2;
  localparam selectorCode selRead = 8'd3;
  localparam selectorCode selCount = 8'd4;

  // APB register map
  localparam logic [7:0] regControl = 8'h00;
  localparam logic [7:0] regStatus = 8'h04;
  localparam logic [7:0] regVectorLow = 8'h08;
  localparam logic [7:0] regVectorHigh = 8'h0C;
  localparam logic [7:0] regVectorCommit = 8'h10;
  localparam logic [7:0] regFailAddress = 8'h14;

endpackage

//--- benchSequencer.sv
`timescale 1ns/1ps

module benchSequencer #(
  parameter int ProgramDepth = 64
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic endSeen,
  input  logic done,
  output logic running,
  output logic issue,
  output logic [$clog2(ProgramDepth)-1:0] issueAddress
);

  localparam int AddrWidth = $clog2(ProgramDepth);

  typedef enum logic [1:0] {
    idle,
    issuing,
    draining
  } seqState;

  seqState state;

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= idle;
      issueAddress <= '0;
    end else if (start) begin
      state <= issuing;
      issueAddress <= '0;
    end else begin
      case (state)
        issuing: begin
          issueAddress <= issueAddress + 1'b1;
          if (done) begin
            state <= idle;
          end else if (endSeen) begin
            state <= draining;
          end
        end
        // Wait for the end vector to reach the checker
        draining: if (done) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  assign running = (state != idle);
  assign issue = (state == issuing);

  noAddressWrap: assert property (@(posedge clk) disable iff (!reset)
    (issue && issueAddress == AddrWidth'(ProgramDepth - 1)) |=> !issue);

endmodule

//--- benchTop.sv
`timescale 1ns/1ps

module benchTop #(
  parameter int NumHandles = 4,
  parameter int Depth = 16,
  parameter int ProgramDepth = 64
) (
  input  logic clk,
  input  logic reset,
  input  logic [7:0] paddr,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  benchPkg::apbData pwdata,
  output benchPkg::apbData prdata,
  output logic pready,
  output logic pslverr
);

  localparam int AddrWidth = $clog2(ProgramDepth);

  // Control and program load
  logic running, done, failed, start, vecWrite, issue, endSeen;
  logic [AddrWidth-1:0] failAddress, vecWriteAddress, issueAddress;
  benchPkg::vectorWord vecWriteData;

  // Fetch and decode
  benchPkg::vectorWord word;
  logic wordValid;
  logic [AddrWidth-1:0] wordAddress;
  benchPkg::storeOp op;
  benchPkg::handleId handle;
  benchPkg::indexId index;
  benchPkg::byteValue value, expectValue;
  logic mutating, expectBool, isEnd, stageValid;
  logic [AddrWidth-1:0] stageAddress;

  // Execute results
  logic resultBool, resultMutating, resultExpectBool, resultEnd, resultValid;
  benchPkg::byteValue resultValue, resultExpectValue;
  logic [AddrWidth-1:0] resultAddress;

  benchApbRegs #(.ProgramDepth(ProgramDepth)) apbRegs (
    .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .running, .done, .failed, .failAddress, .start,
    .vecWrite, .vecWriteAddress, .vecWriteData
  );

  vectorRam #(.ProgramDepth(ProgramDepth)) vectorMem (
    .clk, .vecWrite, .vecWriteAddress, .vecWriteData,
    .issue, .issueAddress, .word, .wordValid, .wordAddress
  );

  benchSequencer #(.ProgramDepth(ProgramDepth)) sequencer (
    .clk, .reset, .start, .endSeen, .done, .running, .issue, .issueAddress
  );

  vectorDecode #(.NumHandles(NumHandles), .ProgramDepth(ProgramDepth)) decode (
    .clk, .reset, .start, .word, .wordValid, .wordAddress, .endSeen,
    .op, .handle, .index, .value, .mutating, .expectBool, .expectValue,
    .isEnd, .stageValid, .stageAddress
  );

  storeExecute #(.NumHandles(NumHandles), .Depth(Depth), .ProgramDepth(ProgramDepth)) execute (
    .clk, .reset, .start, .op, .handle, .index, .value, .mutating, .expectBool,
    .expectValue, .isEnd, .stageValid, .stageAddress,
    .resultBool, .resultValue, .resultMutating, .resultExpectBool, .resultExpectValue,
    .resultEnd, .resultValid, .resultAddress
  );

  resultCheck #(.ProgramDepth(ProgramDepth)) check (
    .clk, .reset, .start, .resultBool, .resultValue, .resultMutating,
    .resultExpectBool, .resultExpectValue, .resultEnd, .resultValid, .resultAddress,
    .done, .failed, .failAddress
  );

endmodule

//--- list.f
benchPkg.sv
benchApbRegs.sv
vectorRam.sv
benchSequencer.sv
vectorDecode.sv
storeExecute.sv
resultCheck.sv
benchTop.sv
tbBench.sv

//--- resultCheck.sv
`timescale 1ns/1ps

module resultCheck #(
  parameter int ProgramDepth = 64
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic resultBool,
  input  benchPkg::byteValue resultValue,
  input  logic resultMutating,
  input  logic resultExpectBool,
  input  benchPkg::byteValue resultExpectValue,
  input  logic resultEnd,
  input  logic resultValid,
  input  logic [$clog2(ProgramDepth)-1:0] resultAddress,
  output logic done,
  output logic failed,
  output logic [$clog2(ProgramDepth)-1:0] failAddress
);

  logic mismatch;

  // Only queries are judged, end and mutating vectors never fail
  assign mismatch = !resultEnd && !resultMutating &&
                    ((resultBool != resultExpectBool) || (resultValue != resultExpectValue));

  always_ff @(posedge clk) begin
    if (!reset || start) begin
      done <= 1'b0;
      failed <= 1'b0;
      failAddress <= '0;
    end else if (resultValid && !done && (resultEnd || mismatch)) begin
      // First verdict sticks until the next start
      done <= 1'b1;
      failed <= mismatch;
      failAddress <= resultAddress;
    end
  end

endmodule

//--- storeExecute.sv
`timescale 1ns/1ps

module storeExecute #(
  parameter int NumHandles = 4,
  parameter int Depth = 16,
  parameter int ProgramDepth = 64
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  benchPkg::storeOp op,
  input  benchPkg::handleId handle,
  input  benchPkg::indexId index,
  input  benchPkg::byteValue value,
  input  logic mutating,
  input  logic expectBool,
  input  benchPkg::byteValue expectValue,
  input  logic isEnd,
  input  logic stageValid,
  input  logic [$clog2(ProgramDepth)-1:0] stageAddress,
  output logic resultBool,
  output benchPkg::byteValue resultValue,
  output logic resultMutating,
  output logic resultExpectBool,
  output benchPkg::byteValue resultExpectValue,
  output logic resultEnd,
  output logic resultValid,
  output logic [$clog2(ProgramDepth)-1:0] resultAddress
);

  localparam int HandleWidth = (NumHandles > 1) ? $clog2(NumHandles) : 1;
  localparam int IndexWidth = (Depth > 1) ? $clog2(Depth) : 1;

  logic [Depth-1:0] validBits [NumHandles];
  benchPkg::byteValue values [NumHandles][Depth];
  logic [HandleWidth-1:0] handleSel;
  // Depth is a power of two, so the low bits give index modulo Depth
  logic [IndexWidth-1:0] indexSel;
  logic nextBool;
  benchPkg::byteValue nextValue;

  assign handleSel = handle[HandleWidth-1:0];
  assign indexSel = index[IndexWidth-1:0];

  //////////////////////////////////////////////////
  // Store state
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!reset || start) begin
      for (int h = 0; h < NumHandles; h++) validBits[h] <= '0;
    end else if (stageValid) begin
      case (op)
        benchPkg::opWrite: validBits[handleSel][indexSel] <= 1'b1;
        benchPkg::opClear: validBits[handleSel] <= '0;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (stageValid && op == benchPkg::opWrite) values[handleSel][indexSel] <= value;
  end

  // Queries see the store before this vector's own update
  always_comb begin
    nextBool = 1'b0;
    nextValue = '0;
    case (op)
      benchPkg::opRead: begin
        nextBool = validBits[handleSel][indexSel];
        if (validBits[handleSel][indexSel]) nextValue = values[handleSel][indexSel];
      end
      benchPkg::opCount: begin
        nextBool = |validBits[handleSel];
        nextValue = benchPkg::byteValue'($countones(validBits[handleSel]));
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset) resultValid <= 1'b0;
    else resultValid <= stageValid;
  end

  always_ff @(posedge clk) begin
    resultBool <= nextBool;
    resultValue <= nextValue;
    resultMutating <= mutating;
    resultExpectBool <= expectBool;
    resultExpectValue <= expectValue;
    resultEnd <= isEnd;
    resultAddress <= stageAddress;
  end

  legalOp: assert property (@(posedge clk) disable iff (!reset)
    stageValid |-> op inside {benchPkg::opNone, benchPkg::opWrite, benchPkg::opClear,
                              benchPkg::opRead, benchPkg::opCount});

endmodule

//--- tbBench.sv
`timescale 1ns/1ps

module tbBench;

  localparam int NumHandles = 4;
  localparam int Depth = 16;
  localparam int ProgramDepth = 64;
  localparam int ProgLen = 40;
  localparam int DirLen = 12;
  // Three random programs, one corrupted vector and the directed program
  localparam int TotalVectors = 3 * ProgLen + 1 + DirLen;
  localparam int TimeoutCycles = TotalVectors * 40 + 1000;

  logic clk;
  logic reset;
  logic [7:0] paddr;
  logic psel;
  logic penable;
  logic pwrite;
  benchPkg::apbData pwdata;
  benchPkg::apbData prdata;
  logic pready;
  logic pslverr;

  // Store model and the program being built
  logic [Depth-1:0] refValid [NumHandles];
  benchPkg::byteValue refValue [NumHandles][Depth];
  benchPkg::vectorWord prog [$];
  int unsigned cycleCount;

  benchTop #(.NumHandles(NumHandles), .Depth(Depth), .ProgramDepth(ProgramDepth)) UUT (
    .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Some tests failed");
      $fatal(1, "timeout");
    end
  end

  task automatic checkEqual(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Some tests failed");
      $fatal(1, "mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Store reference model
  //////////////////////////////////////////////////

  // Applies one vector and returns {boolean, value}
  function automatic logic [8:0] referenceStep(input benchPkg::vectorWord v);
    benchPkg::selectorCode sel;
    int h;
    int idx;
    int count;
    logic [8:0] result;
    sel = v[benchPkg::selectorLsb +: 8];
    h = int'(v[benchPkg::handleLsb +: 8]);
    idx = int'(v[benchPkg::indexLsb +: 8]) % Depth;
    result = '0;
    count = 0;
    if (h < NumHandles) begin
      case (sel)
        benchPkg::selWrite: begin
          refValid[h][idx] = 1'b1;
          refValue[h][idx] = v[benchPkg::valueLsb +: 8];
        end
        benchPkg::selClear: refValid[h] = '0;
        benchPkg::selRead: begin
          result[8] = refValid[h][idx];
          result[7:0] = refValid[h][idx] ? refValue[h][idx] : 8'h00;
        end
        benchPkg::selCount: begin
          for (int i = 0; i < Depth; i++) begin
            if (refValid[h][i]) count++;
          end
          result = {count != 0, 8'(count)};
        end
        default: ;
      endcase
    end
    return result;
  endfunction

  // Start of a run empties the store
  task automatic newProgram();
    for (int h = 0; h < NumHandles; h++) refValid[h] = '0;
    prog.delete();
  endtask

  task automatic addVector(input benchPkg::selectorCode sel, input int h, input int idx,
                           input benchPkg::byteValue val);
    benchPkg::vectorWord v;
    logic [8:0] res;
    logic mut;
    mut = (sel == benchPkg::selWrite) || (sel == benchPkg::selClear);
    v = '0;
    v[benchPkg::mutatingBit] = mut;
    v[benchPkg::handleLsb +: 8] = 8'(h);
    v[benchPkg::indexLsb +: 8] = 8'(idx);
    v[benchPkg::valueLsb +: 8] = val;
    v[benchPkg::selectorLsb +: 8] = sel;
    res = referenceStep(v);
    if (!mut) begin
      v[benchPkg::expectBoolBit] = res[8];
      v[benchPkg::expectValueLsb +: 8] = res[7:0];
    end
    prog.push_back(v);
  endtask

  task automatic addEnd();
    benchPkg::vectorWord v;
    v = '0;
    v[benchPkg::endBit] = 1'b1;
    prog.push_back(v);
  endtask

  // Leading vectors alternate count and read over the handles
  task automatic makeRandomProgram(input int len, input int leading, input bit allowBad);
    benchPkg::selectorCode sel;
    int h;
    int r;
    newProgram();
    for (int i = 0; i < len - 1; i++) begin
      h = int'($urandom_range(0, NumHandles - 1));
      r = int'($urandom_range(0, 9));
      if (i < leading) begin
        sel = (i % 2 == 0) ? benchPkg::selCount : benchPkg::selRead;
        h = (i / 2) % NumHandles;
      end else begin
        sel = (r < 4) ? benchPkg::selWrite : (r < 5) ? benchPkg::selClear :
              (r < 8) ? benchPkg::selRead : benchPkg::selCount;
        if (allowBad && $urandom_range(0, 7) == 0) sel = 8'($urandom_range(5, 255));
        if (allowBad && $urandom_range(0, 7) == 0) h = int'($urandom_range(NumHandles, 255));
      end
      addVector(sel, h, int'($urandom_range(0, 31)), 8'($urandom));
    end
    addEnd();
  endtask

  //////////////////////////////////////////////////
  // APB access
  //////////////////////////////////////////////////

  task automatic apbTransfer(input logic write, input logic [7:0] addr,
                             input benchPkg::apbData wdata,
                             output benchPkg::apbData rdata, output logic err);
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= write;
    paddr <= addr;
    pwdata <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    // Mid-cycle sample of the access phase
    @(negedge clk);
    rdata = prdata;
    err = pslverr;
    checkEqual(pready, 1'b1, "pready in access phase");
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic writeReg(input logic [7:0] addr, input benchPkg::apbData data,
                          input logic expectErr);
    benchPkg::apbData rdata;
    logic err;
    apbTransfer(1'b1, addr, data, rdata, err);
    checkEqual(err, expectErr, $sformatf("pslverr on write to %02h", addr));
  endtask

  task automatic readReg(input logic [7:0] addr, output benchPkg::apbData data,
                         input logic expectErr);
    logic err;
    apbTransfer(1'b0, addr, '0, data, err);
    checkEqual(err, expectErr, $sformatf("pslverr on read of %02h", addr));
  endtask

  task automatic loadVector(input int i);
    writeReg(benchPkg::regVectorLow, prog[i][31:0], 1'b0);
    writeReg(benchPkg::regVectorHigh, prog[i][63:32], 1'b0);
    writeReg(benchPkg::regVectorCommit, benchPkg::apbData'(i), 1'b0);
  endtask

  task automatic loadProgram();
    for (int i = 0; i < prog.size(); i++) loadVector(i);
  endtask

  // Poll status until done, then check the verdict
  task automatic waitAndCheck(input bit expectPass, input int failAt);
    benchPkg::apbData status;
    do begin
      readReg(benchPkg::regStatus, status, 1'b0);
    end while (!status[1]);
    readReg(benchPkg::regStatus, status, 1'b0);
    checkEqual(status, expectPass ? 32'd6 : 32'd2, "status after run");
    if (!expectPass) begin
      readReg(benchPkg::regFailAddress, status, 1'b0);
      checkEqual(status, failAt, "fail address");
    end
  endtask

  initial begin
    benchPkg::apbData data;
    benchPkg::vectorWord corrupted;
    int k;
    clk = 1'b0;
    reset = 1'b0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    cycleCount = 0;
    void'($urandom(32'hcc79_608d));
    repeat (2) @(posedge clk);
    reset <= 1'b1;

    // Idle status and unmapped offsets
    readReg(benchPkg::regStatus, data, 1'b0);
    checkEqual(data, 0, "status after reset");
    readReg(8'h18, data, 1'b1);
    writeReg(8'h3C, 32'h1, 1'b1);

    // Random program that must pass
    makeRandomProgram(ProgLen, 2, 1'b0);
    loadProgram();
    writeReg(benchPkg::regControl, 1, 1'b0);
    waitAndCheck(1'b1, 0);

    // One wrong expectation at a query vector
    k = int'($urandom_range(0, prog.size() - 2));
    while (prog[k][benchPkg::mutatingBit]) k = (k + 1) % (prog.size() - 1);
    corrupted = prog[k];
    corrupted[benchPkg::expectValueLsb +: 8] =
        corrupted[benchPkg::expectValueLsb +: 8] ^ 8'($urandom_range(1, 255));
    prog[k] = corrupted;
    loadVector(k);
    writeReg(benchPkg::regControl, 1, 1'b0);
    waitAndCheck(1'b0, k);

    // Leading queries see the store that start emptied
    makeRandomProgram(ProgLen, 2 * NumHandles, 1'b0);
    loadProgram();
    writeReg(benchPkg::regControl, 1, 1'b0);
    waitAndCheck(1'b1, 0);

    // Illegal selectors and handles
    newProgram();
    addVector(benchPkg::selWrite, 0, 3, 8'h5A);
    addVector(8'd9, 0, 3, 8'hA5);
    addVector(benchPkg::selWrite, 4, 3, 8'hA5);
    addVector(benchPkg::selWrite, 132, 3, 8'h77);
    addVector(8'd255, 1, 3, 8'h11);
    addVector(benchPkg::selRead, 0, 3, 8'h00);
    addVector(benchPkg::selRead, 4, 3, 8'h00);
    addVector(benchPkg::selCount, 200, 0, 8'h00);
    addVector(benchPkg::selClear, 8, 0, 8'h00);
    addVector(benchPkg::selCount, 0, 0, 8'h00);
    addVector(benchPkg::selRead, 0, 19, 8'h00);
    addEnd();
    loadProgram();
    writeReg(benchPkg::regControl, 1, 1'b0);
    waitAndCheck(1'b1, 0);

    // Writes during a run are refused
    makeRandomProgram(ProgLen, 0, 1'b1);
    loadProgram();
    writeReg(benchPkg::regControl, 1, 1'b0);
    // This word fails the run if it reaches a vector not yet issued
    writeReg(benchPkg::regVectorLow, 32'hDEAD_BE02, 1'b1);
    writeReg(benchPkg::regVectorCommit, benchPkg::apbData'(ProgLen - 2), 1'b1);
    writeReg(benchPkg::regControl, 1, 1'b1);
    waitAndCheck(1'b1, 0);

    $display("All tests passed");
    $finish;
  end

endmodule

//--- vectorDecode.sv
`timescale 1ns/1ps

module vectorDecode #(
  parameter int NumHandles = 4,
  parameter int ProgramDepth = 64
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  benchPkg::vectorWord word,
  input  logic wordValid,
  input  logic [$clog2(ProgramDepth)-1:0] wordAddress,
  output logic endSeen,
  output benchPkg::storeOp op,
  output benchPkg::handleId handle,
  output benchPkg::indexId index,
  output benchPkg::byteValue value,
  output logic mutating,
  output logic expectBool,
  output benchPkg::byteValue expectValue,
  output logic isEnd,
  output logic stageValid,
  output logic [$clog2(ProgramDepth)-1:0] stageAddress
);

  benchPkg::storeOp decodedOp;
  benchPkg::handleId handleField;
  logic accept;

  assign handleField = word[benchPkg::handleLsb +: 8];
  // Nothing passes once the end vector went through
  assign accept = wordValid && !endSeen;

  always_comb begin
    case (word[benchPkg::selectorLsb +: 8])
      benchPkg::selWrite: decodedOp = benchPkg::opWrite;
      benchPkg::selClear: decodedOp = benchPkg::opClear;
      benchPkg::selRead: decodedOp = benchPkg::opRead;
      benchPkg::selCount: decodedOp = benchPkg::opCount;
      default: decodedOp = benchPkg::opNone;
    endcase
    if (handleField >= NumHandles) decodedOp = benchPkg::opNone;
  end

  always_ff @(posedge clk) begin
    if (!reset || start) begin
      endSeen <= 1'b0;
      stageValid <= 1'b0;
    end else begin
      stageValid <= accept;
      if (accept && word[benchPkg::endBit]) endSeen <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    op <= decodedOp;
    handle <= handleField;
    index <= word[benchPkg::indexLsb +: 8];
    value <= word[benchPkg::valueLsb +: 8];
    mutating <= word[benchPkg::mutatingBit];
    expectBool <= word[benchPkg::expectBoolBit];
    expectValue <= word[benchPkg::expectValueLsb +: 8];
    isEnd <= word[benchPkg::endBit];
    stageAddress <= wordAddress;
  end

endmodule

//--- vectorRam.sv
`timescale 1ns/1ps

module vectorRam #(
  parameter int ProgramDepth = 64
) (
  input  logic clk,
  input  logic vecWrite,
  input  logic [$clog2(ProgramDepth)-1:0] vecWriteAddress,
  input  benchPkg::vectorWord vecWriteData,
  input  logic issue,
  input  logic [$clog2(ProgramDepth)-1:0] issueAddress,
  output benchPkg::vectorWord word,
  output logic wordValid,
  output logic [$clog2(ProgramDepth)-1:0] wordAddress
);

  benchPkg::vectorWord mem [ProgramDepth];

  always_ff @(posedge clk) begin
    if (vecWrite) begin
      mem[vecWriteAddress] <= vecWriteData;
    end
  end

  // Registered read, the address rides along with the word
  always_ff @(posedge clk) begin
    word <= mem[issueAddress];
    wordValid <= issue;
    wordAddress <= issueAddress;
  end

endmodule
